// File: fetch_pkg.sv
/*
  Shared constants and types for the instruction fetch front end.
  Modules import this package inside their body and use scoped names
  in their port lists.
*/

package fetch_pkg;

  //////////////////////////////////////////////////
  // Sizes and limits
  //////////////////////////////////////////////////

  // Width of every fetch address and instruction address
  localparam int ADDR_W = 32;

  // Granted memory reads that may still wait for their response
  // The alignment buffer keeps its outstanding counter within this value
  localparam int MAX_OUTSTANDING = 2;

  //////////////////////////////////////////////////
  // Types
  //////////////////////////////////////////////////

  // Size of the instruction at the FIFO head
  // An instruction is full size when bits 1:0 of its low halfword are both one,
  // otherwise it is a compressed 16-bit instruction
  typedef enum logic {
    INSTR_C16 = 1'b0,
    INSTR_W32 = 1'b1
  } instr_size_e;

  // Prefetcher state
  // PF_WAIT_GNT keeps a request on the bus until memory grants it
  typedef enum logic {
    PF_IDLE     = 1'b0,
    PF_WAIT_GNT = 1'b1
  } pf_state_e;

endpackage

// File: prefetcher.sv
/*
  Word prefetcher for the fetch front end.
  Holds the address of the next word to fetch and drives the memory request.
  The alignment buffer decides when a word may be fetched and when to
  redirect to a new address.
*/

`timescale 1ns/1ps

module prefetcher (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         fetch_valid_i,
  input  logic                         fetch_branch_i,
  input  logic [fetch_pkg::ADDR_W-1:0] fetch_branch_addr_i,
  input  logic                         mem_gnt_i,
  output logic                         fetch_ready_o,
  output logic                         mem_req_o,
  output logic [fetch_pkg::ADDR_W-1:0] mem_addr_o
);
  import fetch_pkg::*;

  // Request state and the address of the next word
  pf_state_e         state_q;
  pf_state_e         state_d;
  logic [ADDR_W-1:0] addr_q;
  logic [ADDR_W-1:0] addr_d;

  //////////////////////////////////////////////////
  // Memory request
  //////////////////////////////////////////////////

  // A request is raised when the buffer asks for a word
  // A request left waiting for its grant stays on the bus,
  // but a branch or kill drops it and the buffer decides again
  assign mem_req_o = fetch_valid_i || ((state_q == PF_WAIT_GNT) && !fetch_branch_i);

  // The branch address goes out in the same cycle as the branch
  assign mem_addr_o = fetch_branch_i ? fetch_branch_addr_i : addr_q;

  // The buffer counts one outstanding read per accepted request
  assign fetch_ready_o = mem_req_o && mem_gnt_i;

  //////////////////////////////////////////////////
  // Next state and next address
  //////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    addr_d  = addr_q;

    // The address moves on by one word after each grant
    // A redirect without a grant still loads the branch address
    if (fetch_ready_o) begin
      addr_d = mem_addr_o + ADDR_W'(4);
    end else if (fetch_branch_i) begin
      addr_d = fetch_branch_addr_i;
    end

    case (state_q)
      PF_IDLE: begin
        if (mem_req_o && !mem_gnt_i) begin
          state_d = PF_WAIT_GNT;
        end
      end
      PF_WAIT_GNT: begin
        // Leave when the grant arrives or a redirect drops the request
        if (!mem_req_o || mem_gnt_i) begin
          state_d = PF_IDLE;
        end
      end
      default: begin
        state_d = PF_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= PF_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
    end
  end

endmodule

// File: alignment_buffer.sv
/*
  Alignment buffer of the fetch front end.
  Stores returned memory words in a small FIFO, tracks outstanding reads and
  cuts the word stream into 16-bit and 32-bit instructions with their address.
  A branch or kill empties the FIFO and discards responses still in flight.
*/

`timescale 1ns/1ps

module alignment_buffer #(
  parameter int FIFO_DEPTH = 3
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         pc_set_i,
  input  logic                         kill_if_i,
  input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
  input  logic                         fetch_ready_i,
  input  logic                         mem_rvalid_i,
  input  logic [31:0]                  mem_rdata_i,
  input  logic                         instr_ready_i,
  output logic                         fetch_valid_o,
  output logic                         fetch_branch_o,
  output logic [fetch_pkg::ADDR_W-1:0] fetch_branch_addr_o,
  output logic                         instr_valid_o,
  output logic [31:0]                  instr_rdata_o,
  output logic [fetch_pkg::ADDR_W-1:0] instr_addr_o,
  output logic                         instr_compressed_o
);
  import fetch_pkg::*;

  localparam int PTR_W  = $clog2(FIFO_DEPTH);
  localparam int FILL_W = $clog2(FIFO_DEPTH + 1);
  localparam int CNT_W  = $clog2(MAX_OUTSTANDING + 1);
  localparam int SLOT_W = $clog2(FIFO_DEPTH + MAX_OUTSTANDING + 1);

  // Word storage with one valid bit per entry
  logic [31:0]           rdata_q [FIFO_DEPTH];
  logic [FIFO_DEPTH-1:0] valid_q;
  logic [FIFO_DEPTH-1:0] valid_d;
  logic [PTR_W-1:0]      wptr_q;
  logic [PTR_W-1:0]      wptr_d;
  logic [PTR_W-1:0]      rptr_q;
  logic [PTR_W-1:0]      rptr_d;
  logic [PTR_W-1:0]      rptr2;
  logic [FILL_W-1:0]     fill_q;
  logic [FILL_W-1:0]     fill_d;

  // Read counters and fetch enable
  logic [CNT_W-1:0]      outstanding_q;
  logic [CNT_W-1:0]      outstanding_d;
  logic [CNT_W-1:0]      n_flush_q;
  logic [CNT_W-1:0]      n_flush_d;
  logic [CNT_W-1:0]      outs_after_resp;
  logic                  fetch_en_q;
  logic                  fetch_en_d;

  // Head instruction position
  logic                  hw_q;
  logic                  hw_d;
  logic [ADDR_W-1:0]     addr_q;
  logic [ADDR_W-1:0]     addr_d;

  logic                  branch;
  logic                  resp_valid_gated;
  logic                  consume;
  logic                  pop;
  logic [15:0]           head_lo;
  instr_size_e           head_size;
  logic                  head_valid;
  logic [31:0]           head_instr;
  logic [SLOT_W-1:0]     used_slots;
  logic                  space_ok;
  logic                  branch_room;

  // Pointers wrap at the FIFO depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    return nxt;
  endfunction

  //////////////////////////////////////////////////
  // Branch, flush and fetch control
  //////////////////////////////////////////////////

  assign branch              = pc_set_i || kill_if_i;
  assign fetch_branch_o      = branch;
  assign fetch_branch_addr_o = {branch_addr_i[ADDR_W-1:2], 2'b00};

  // Reads still owed once the response of this cycle is counted
  assign outs_after_resp = outstanding_q - CNT_W'(mem_rvalid_i);

  // Responses that belong to fetches before a branch never reach the FIFO
  assign resp_valid_gated = mem_rvalid_i && (n_flush_q == '0) && !branch;

  // Every outstanding read owns a free entry, so a response always finds room
  assign used_slots = SLOT_W'(fill_q) + SLOT_W'(outstanding_q);

  // Sequential fetches keep one read slot free for the request of a branch
  assign space_ok = (used_slots < SLOT_W'(FIFO_DEPTH)) &&
                    (outstanding_q < CNT_W'(MAX_OUTSTANDING - 1));

  // A branch requests its word at once, unless the read slots are all taken
  assign branch_room = outs_after_resp < CNT_W'(MAX_OUTSTANDING);

  assign fetch_valid_o = pc_set_i ? branch_room : (fetch_en_q && !kill_if_i && space_ok);

  //////////////////////////////////////////////////
  // Head instruction assembly
  //////////////////////////////////////////////////

  assign rptr2 = ptr_inc(rptr_q);

  always_comb begin
    head_lo   = hw_q ? rdata_q[rptr_q][31:16] : rdata_q[rptr_q][15:0];
    head_size = (head_lo[1:0] == 2'b11) ? INSTR_W32 : INSTR_C16;

    if (head_size == INSTR_C16) begin
      // Compressed instructions leave the upper halfword at zero
      head_instr = {16'h0000, head_lo};
      head_valid = valid_q[rptr_q];
    end else if (!hw_q) begin
      head_instr = rdata_q[rptr_q];
      head_valid = valid_q[rptr_q];
    end else begin
      // A full instruction in the upper half straddles into the next entry
      head_instr = {rdata_q[rptr2][15:0], rdata_q[rptr_q][31:16]};
      head_valid = valid_q[rptr_q] && valid_q[rptr2];
    end
  end

  // No instruction is offered in a branch or kill cycle
  assign instr_valid_o      = head_valid && !branch;
  assign instr_rdata_o      = head_instr;
  assign instr_addr_o       = addr_q;
  assign instr_compressed_o = (head_size == INSTR_C16);

  assign consume = instr_valid_o && instr_ready_i;

  // The head entry leaves once its upper halfword is used up
  assign pop = consume && (hw_q || (head_size == INSTR_W32));

  //////////////////////////////////////////////////
  // Next state
  //////////////////////////////////////////////////

  always_comb begin
    valid_d = valid_q;
    wptr_d  = wptr_q;
    rptr_d  = rptr_q;
    fill_d  = fill_q;
    hw_d    = hw_q;
    addr_d  = addr_q;

    if (branch) begin
      // Empty the FIFO and start at the halfword the branch names
      valid_d = '0;
      wptr_d  = '0;
      rptr_d  = '0;
      fill_d  = '0;
      hw_d    = branch_addr_i[1];
      addr_d  = {branch_addr_i[ADDR_W-1:1], 1'b0};
    end else begin
      if (resp_valid_gated) begin
        valid_d[wptr_q] = 1'b1;
        wptr_d          = ptr_inc(wptr_q);
      end
      if (consume) begin
        // A compressed instruction flips the halfword offset, a full one keeps it
        hw_d   = hw_q ^ (head_size == INSTR_C16);
        addr_d = addr_q + ((head_size == INSTR_C16) ? ADDR_W'(2) : ADDR_W'(4));
      end
      if (pop) begin
        valid_d[rptr_q] = 1'b0;
        rptr_d          = rptr2;
      end
      fill_d = fill_q + FILL_W'(resp_valid_gated) - FILL_W'(pop);
    end
  end

  always_comb begin
    outstanding_d = outstanding_q + CNT_W'(fetch_ready_i) - CNT_W'(mem_rvalid_i);

    // The flush counter takes over every read issued before the branch
    if (branch) begin
      n_flush_d = outs_after_resp;
    end else if (mem_rvalid_i && (n_flush_q != '0)) begin
      n_flush_d = n_flush_q - CNT_W'(1);
    end else begin
      n_flush_d = n_flush_q;
    end

    // Fetching runs from a pc_set until the next kill
    if (pc_set_i) begin
      fetch_en_d = 1'b1;
    end else if (kill_if_i) begin
      fetch_en_d = 1'b0;
    end else begin
      fetch_en_d = fetch_en_q;
    end
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (resp_valid_gated) begin
      rdata_q[wptr_q] <= mem_rdata_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q       <= '0;
      wptr_q        <= '0;
      rptr_q        <= '0;
      fill_q        <= '0;
      outstanding_q <= '0;
      n_flush_q     <= '0;
      fetch_en_q    <= 1'b0;
      hw_q          <= 1'b0;
      addr_q        <= '0;
    end else begin
      valid_q       <= valid_d;
      wptr_q        <= wptr_d;
      rptr_q        <= rptr_d;
      fill_q        <= fill_d;
      outstanding_q <= outstanding_d;
      n_flush_q     <= n_flush_d;
      fetch_en_q    <= fetch_en_d;
      hw_q          <= hw_d;
      addr_q        <= addr_d;
    end
  end

endmodule

// File: fetch_unit.sv
/*
  Top level of the instruction fetch front end.
  Joins the prefetcher and the alignment buffer between the memory port
  and the instruction port. FIFO_DEPTH sets the alignment buffer size.
*/

`timescale 1ns/1ps

module fetch_unit #(
  parameter int FIFO_DEPTH = 3
) (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         pc_set_i,
  input  logic                         kill_if_i,
  input  logic [fetch_pkg::ADDR_W-1:0] branch_addr_i,
  input  logic                         instr_ready_i,
  input  logic                         mem_gnt_i,
  input  logic                         mem_rvalid_i,
  input  logic [31:0]                  mem_rdata_i,
  output logic                         mem_req_o,
  output logic [fetch_pkg::ADDR_W-1:0] mem_addr_o,
  output logic                         instr_valid_o,
  output logic [31:0]                  instr_rdata_o,
  output logic [fetch_pkg::ADDR_W-1:0] instr_addr_o,
  output logic                         instr_compressed_o
);
  import fetch_pkg::*;

  // Handshake between the buffer and the prefetcher
  logic              fetch_valid;
  logic              fetch_ready;
  logic              fetch_branch;
  logic [ADDR_W-1:0] fetch_branch_addr;

  prefetcher u_prefetcher (
    .clk                 (clk),
    .rst_n               (rst_n),
    .fetch_valid_i       (fetch_valid),
    .fetch_branch_i      (fetch_branch),
    .fetch_branch_addr_i (fetch_branch_addr),
    .mem_gnt_i           (mem_gnt_i),
    .fetch_ready_o       (fetch_ready),
    .mem_req_o           (mem_req_o),
    .mem_addr_o          (mem_addr_o)
  );

  alignment_buffer #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_alignment_buffer (
    .clk                 (clk),
    .rst_n               (rst_n),
    .pc_set_i            (pc_set_i),
    .kill_if_i           (kill_if_i),
    .branch_addr_i       (branch_addr_i),
    .fetch_ready_i       (fetch_ready),
    .mem_rvalid_i        (mem_rvalid_i),
    .mem_rdata_i         (mem_rdata_i),
    .instr_ready_i       (instr_ready_i),
    .fetch_valid_o       (fetch_valid),
    .fetch_branch_o      (fetch_branch),
    .fetch_branch_addr_o (fetch_branch_addr),
    .instr_valid_o       (instr_valid_o),
    .instr_rdata_o       (instr_rdata_o),
    .instr_addr_o        (instr_addr_o),
    .instr_compressed_o  (instr_compressed_o)
  );

endmodule

// File: alignment_buffer_properties.sv
/*
  Concurrent assertions on the alignment buffer internals.
  Bound into every alignment_buffer instance at the end of this file.
*/

`timescale 1ns/1ps

module alignment_buffer_properties #(
  parameter int FIFO_DEPTH = 3
) (
  input logic                                                clk,
  input logic                                                rst_n,
  input logic                                                pc_set_i,
  input logic                                                kill_if_i,
  input logic [fetch_pkg::ADDR_W-1:0]                        branch_addr_i,
  input logic                                                instr_ready_i,
  input logic                                                instr_valid_i,
  input logic [fetch_pkg::ADDR_W-1:0]                        instr_addr_i,
  input logic                                                resp_valid_i,
  input logic [FIFO_DEPTH-1:0]                               entry_valid_i,
  input logic [$clog2(FIFO_DEPTH)-1:0]                       wptr_i,
  input logic [$clog2(FIFO_DEPTH)-1:0]                       rptr_i,
  input logic [$clog2(fetch_pkg::MAX_OUTSTANDING + 1)-1:0]   outstanding_i
);
  import fetch_pkg::*;

  // Address the first instruction after a pc_set has to carry
  logic              first_pending;
  logic [ADDR_W-1:0] first_addr;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      first_pending <= 1'b0;
      first_addr    <= '0;
    end else if (pc_set_i) begin
      first_pending <= 1'b1;
      first_addr    <= {branch_addr_i[ADDR_W-1:1], 1'b0};
    end else if (kill_if_i || (instr_valid_i && instr_ready_i)) begin
      first_pending <= 1'b0;
    end
  end

  //////////////////////////////////////////////////

  no_overwrite: assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> !entry_valid_i[wptr_i])
    else $error("Response written into an occupied FIFO entry");

  empty_after_pc_set: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |=> (entry_valid_i == '0))
    else $error("FIFO not empty after pc_set");

  no_valid_on_pc_set: assert property (@(posedge clk) disable iff (!rst_n)
    pc_set_i |-> !instr_valid_i)
    else $error("Instruction offered during pc_set");

  outstanding_limit: assert property (@(posedge clk) disable iff (!rst_n)
    int'(outstanding_i) <= MAX_OUTSTANDING)
    else $error("Too many outstanding reads");

  pointer_range: assert property (@(posedge clk) disable iff (!rst_n)
    (int'(wptr_i) < FIFO_DEPTH) && (int'(rptr_i) < FIFO_DEPTH))
    else $error("FIFO pointer out of range");

  first_instr_addr: assert property (@(posedge clk) disable iff (!rst_n)
    (first_pending && instr_valid_i) |-> (instr_addr_i == first_addr))
    else $error("First instruction after a branch has the wrong address");

endmodule

bind alignment_buffer alignment_buffer_properties #(
  .FIFO_DEPTH (FIFO_DEPTH)
) u_properties (
  .clk           (clk),
  .rst_n         (rst_n),
  .pc_set_i      (pc_set_i),
  .kill_if_i     (kill_if_i),
  .branch_addr_i (branch_addr_i),
  .instr_ready_i (instr_ready_i),
  .instr_valid_i (instr_valid_o),
  .instr_addr_i  (instr_addr_o),
  .resp_valid_i  (resp_valid_gated),
  .entry_valid_i (valid_q),
  .wptr_i        (wptr_q),
  .rptr_i        (rptr_q),
  .outstanding_i (outstanding_q)
);

// File: tb_fetch_unit.sv
/*
  Testbench for the fetch front end. A random-latency memory model serves a
  fixed memory image, a compare process checks every consumed instruction
  against a reference walk of that image, and branches and kills are issued
  while reads are still in flight.
*/

`timescale 1ns/1ps

module tb_fetch_unit;
  import fetch_pkg::*;

  logic              clk;
  logic              rst_n;
  logic              pc_set_i;
  logic              kill_if_i;
  logic [ADDR_W-1:0] branch_addr_i;
  logic              instr_ready_i;
  logic              mem_gnt_i;
  logic              mem_rvalid_i;
  logic [31:0]       mem_rdata_i;
  logic              mem_req_o;
  logic [ADDR_W-1:0] mem_addr_o;
  logic              instr_valid_o;
  logic [31:0]       instr_rdata_o;
  logic [ADDR_W-1:0] instr_addr_o;
  logic              instr_compressed_o;

  integer      seed = 4123;
  int          n_errors = 0;
  int          n_consumed = 0;
  logic        stall_en;
  // Granted reads in order, with the cycles left before their response
  logic [31:0] resp_addr_q[$];
  int          resp_wait_q[$];

  fetch_unit #(.FIFO_DEPTH(3)) uut (
    .clk(clk), .rst_n(rst_n), .pc_set_i(pc_set_i), .kill_if_i(kill_if_i),
    .branch_addr_i(branch_addr_i), .instr_ready_i(instr_ready_i),
    .mem_gnt_i(mem_gnt_i), .mem_rvalid_i(mem_rvalid_i), .mem_rdata_i(mem_rdata_i),
    .mem_req_o(mem_req_o), .mem_addr_o(mem_addr_o), .instr_valid_o(instr_valid_o),
    .instr_rdata_o(instr_rdata_o), .instr_addr_o(instr_addr_o),
    .instr_compressed_o(instr_compressed_o)
  );

  //////////////////////////////////////////////////
  // Memory image and reference model
  //////////////////////////////////////////////////

  // Each word mixes its whole address; bits 1:0 of both halfwords pick the size
  function automatic logic [31:0] mem_word(input logic [31:0] a);
    logic [31:0] h;
    h = (a ^ 32'h5bd1e995) * 32'h9e3779b1;
    h = h ^ (h >> 13);
    h[1:0]   = h[24] ? 2'b11 : 2'b01;
    h[17:16] = h[25] ? 2'b11 : 2'b10;
    return h;
  endfunction

  function automatic logic [15:0] mem_half(input logic [31:0] a);
    logic [31:0] w;
    w = mem_word({a[31:2], 2'b00});
    return a[1] ? w[31:16] : w[15:0];
  endfunction

  // Instruction at pc, its size and the address that follows it
  function automatic void ref_instr(input logic [31:0] pc, output logic [31:0] instr,
                                    output instr_size_e size, output logic [31:0] next_pc);
    logic [15:0] lo;
    lo = mem_half(pc);
    if (lo[1:0] == 2'b11) begin
      instr   = {mem_half(pc + 32'd2), lo};
      size    = INSTR_W32;
      next_pc = pc + 32'd4;
    end else begin
      instr   = {16'h0000, lo};
      size    = INSTR_C16;
      next_pc = pc + 32'd2;
    end
  endfunction

  function automatic logic [31:0] rand_target();
    return {20'h0, 11'($random(seed)), 1'b0};
  endfunction

  //////////////////////////////////////////////////
  // Checking and waiting
  //////////////////////////////////////////////////

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      n_errors++;
      $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("FAIL: see errors above");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic report_timeout(input string what);
    $display("Timed out at %0t ns while waiting for %s", $time, what);
    $display("FAIL: see errors above");
    $fatal(1, "Stopped on a timeout");
  endtask

  // Returns at a falling edge once n more instructions were consumed
  task automatic wait_consumed(input int n);
    int target;
    int cycles;
    target = n_consumed + n;
    cycles = 0;
    while (n_consumed < target) begin
      @(negedge clk);
      cycles++;
      if (cycles > 20 * n + 50) report_timeout("consumed instructions");
    end
  endtask

  // The read queue is sampled at the rising edge where it does not change
  task automatic wait_pending();
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (resp_addr_q.size() == 0) begin
      cycles++;
      if (cycles > 50) report_timeout("a granted memory read");
      @(posedge clk);
    end
    @(negedge clk);
  endtask

  // Both are called at a falling edge and hold their strobe for one cycle
  task automatic branch_to(input logic [31:0] addr);
    pc_set_i      = 1'b1;
    branch_addr_i = addr;
    @(negedge clk);
    pc_set_i = 1'b0;
  endtask

  task automatic kill_fetch();
    kill_if_i = 1'b1;
    @(negedge clk);
    kill_if_i = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // Clock, memory model and ready stalls
  //////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    int idx;
    mem_gnt_i    = 1'b0;
    mem_rvalid_i = 1'b0;
    mem_rdata_i  = 32'h0;
    forever begin
      @(negedge clk);
      mem_rvalid_i = 1'b0;
      mem_rdata_i  = 32'h0;
      // Only the oldest read may answer, which keeps responses in order
      if (resp_addr_q.size() > 0) begin
        if (resp_wait_q[0] == 0) begin
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = mem_word(resp_addr_q.pop_front());
          void'(resp_wait_q.pop_front());
        end
      end
      for (idx = 0; idx < resp_wait_q.size(); idx++) begin
        if (resp_wait_q[idx] > 0) resp_wait_q[idx] = resp_wait_q[idx] - 1;
      end
      mem_gnt_i = ($random(seed) & 3) != 0;
      #1;
      // The request is accepted at the coming rising edge, answered 1 to 3 cycles later
      if (rst_n && mem_req_o && mem_gnt_i) begin
        check("memory address bits 1:0", 32'(mem_addr_o[1:0]), 32'd0);
        resp_addr_q.push_back(mem_addr_o);
        resp_wait_q.push_back(($random(seed) & 32'h7fffffff) % 3);
      end
    end
  end

  initial begin
    instr_ready_i = 1'b1;
    forever begin
      @(negedge clk);
      instr_ready_i = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Compare process
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] exp_addr;
    logic [31:0] e_instr;
    logic [31:0] e_next;
    logic [31:0] held_instr;
    logic [31:0] held_addr;
    instr_size_e e_size;
    logic        held_c;
    logic        held;
    logic        running;
    logic        started;
    exp_addr = '0;
    held     = 1'b0;
    running  = 1'b0;
    started  = 1'b0;
    forever begin
      // Inputs settle at the falling edge, outputs are read 1 ns later
      @(negedge clk);
      #1;
      if (rst_n) begin
        if (pc_set_i) begin
          check("mem_req_o on pc_set", 32'(mem_req_o), 32'd1);
          check("memory address on pc_set", mem_addr_o, {branch_addr_i[31:2], 2'b00});
          check("instr_valid_o on pc_set", 32'(instr_valid_o), 32'd0);
          exp_addr = {branch_addr_i[31:1], 1'b0};
          started  = 1'b1;
          running  = 1'b1;
          held     = 1'b0;
        end else if (kill_if_i) begin
          check("instr_valid_o on kill", 32'(instr_valid_o), 32'd0);
          running = 1'b0;
          held    = 1'b0;
        end else begin
          if (!started) check("mem_req_o before any branch", 32'(mem_req_o), 32'd0);
          if (!running) check("instr_valid_o without fetch", 32'(instr_valid_o), 32'd0);
          // A stalled instruction stays on the port unchanged
          if (held) begin
            check("held instr_valid_o", 32'(instr_valid_o), 32'd1);
            check("held instr_rdata_o", instr_rdata_o, held_instr);
            check("held instr_addr_o", instr_addr_o, held_addr);
            check("held instr_compressed_o", 32'(instr_compressed_o), 32'(held_c));
          end
          if (instr_valid_o && instr_ready_i) begin
            ref_instr(exp_addr, e_instr, e_size, e_next);
            check("instr_addr_o", instr_addr_o, exp_addr);
            check("instr_rdata_o", instr_rdata_o, e_instr);
            check("instr_compressed_o", 32'(instr_compressed_o), 32'(e_size == INSTR_C16));
            exp_addr = e_next;
            n_consumed++;
          end
          held       = instr_valid_o && !instr_ready_i;
          held_instr = instr_rdata_o;
          held_addr  = instr_addr_o;
          held_c     = instr_compressed_o;
        end
      end
    end
  end

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    int i;
    rst_n         = 1'b0;
    pc_set_i      = 1'b0;
    kill_if_i     = 1'b0;
    branch_addr_i = '0;
    stall_en      = 1'b0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;

    // Idle after reset, then a word-aligned start
    repeat (6) @(negedge clk);
    branch_to(32'h0000_0100);
    wait_consumed(40);

    // Start in the upper halfword of a word
    branch_to(32'h0000_020a);
    wait_consumed(40);

    stall_en = 1'b1;
    branch_to(32'h0000_0302);
    wait_consumed(60);

    // Second branch lands while the first one's read is in flight
    for (i = 0; i < 20; i++) begin
      branch_to(rand_target());
      wait_pending();
      branch_to(rand_target());
      wait_consumed(1 + ($random(seed) & 7));
    end

    for (i = 0; i < 8; i++) begin
      branch_to(rand_target());
      wait_pending();
      kill_fetch();
      repeat (1 + ($random(seed) & 3)) @(negedge clk);
      branch_to(rand_target());
      wait_consumed(4);
    end

    if (n_errors == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "Errors were reported");
    end
  end

endmodule

// File: sources.f
fetch_pkg.sv
prefetcher.sv
alignment_buffer.sv
fetch_unit.sv
alignment_buffer_properties.sv
tb_fetch_unit.sv

// File: Makefile
TOP = tb_fetch_unit

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep "PASS: all tests"

clean:
	rm -rf obj_dir
